// ==== logic/gpio_pkg.sv ====
package gpio_pkg;

    //////////////////////////////
    // bus widths
    //////////////////////////////

    localparam int unsigned WB_DATA_W = 32;  // wishbone data word
    localparam int unsigned WB_ADR_W  = 5;   // byte address, 8 words
    localparam int unsigned REG_IDX_W = 3;   // word index

    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_ADR_W-1:0]  wb_adr_t;   // bits 4:2 select register
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    //////////////////////////////
    // register map
    //////////////////////////////

    localparam reg_idx_t REG_OUT_EN   = 3'd0;  // pin output enable
    localparam reg_idx_t REG_OUT_DATA = 3'd1;  // pin output value
    localparam reg_idx_t REG_IN_EN    = 3'd2;  // synchronizer enable
    localparam reg_idx_t REG_IN_DATA  = 3'd3;  // read only
    localparam reg_idx_t REG_IRQ_EN   = 3'd4;
    localparam reg_idx_t REG_IRQ_MODE = 3'd5;  // 0 level, 1 edge
    localparam reg_idx_t REG_IRQ_POL  = 3'd6;  // 0 low/falling, 1 high/rising
    localparam reg_idx_t REG_IRQ_STS  = 3'd7;  // write one to clear edge bits

endpackage

// ==== logic/gpio_sync.sv ====
`timescale 1ns/1ps

module gpio_sync #(
    parameter int unsigned GPIO_WIDTH  = 8,
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [GPIO_WIDTH-1:0] gpio_in,   // asynchronous pins
    input  logic [GPIO_WIDTH-1:0] in_en,     // per-bit enable
    output logic [GPIO_WIDTH-1:0] in_data    // last stage
);

    //////////////////////////////
    // synchronizer chain
    //////////////////////////////

    // stage 0 samples the pins, the last stage is the synchronized value
    logic [SYNC_STAGES-1:0][GPIO_WIDTH-1:0] sync_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            // disabled bits load zero at every stage, no toggling
            sync_q[0] <= gpio_in & in_en;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1] & in_en;  // shift along
            end
        end
    end

    assign in_data = sync_q[SYNC_STAGES-1];  // SYNC_STAGES edges after the pin

endmodule

// ==== logic/gpio_irq.sv ====
`timescale 1ns/1ps

module gpio_irq #(
    parameter int unsigned GPIO_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [GPIO_WIDTH-1:0] in_data,   // synchronized pins
    input  logic [GPIO_WIDTH-1:0] irq_en,
    input  logic [GPIO_WIDTH-1:0] irq_mode,  // 0 level, 1 edge
    input  logic [GPIO_WIDTH-1:0] irq_pol,   // active value per bit
    input  logic [GPIO_WIDTH-1:0] irq_clr,   // write one to clear mask
    output logic [GPIO_WIDTH-1:0] irq_sts,
    output logic                  irq
);

    logic [GPIO_WIDTH-1:0] act;      // active value per bit
    logic [GPIO_WIDTH-1:0] act_dly;  // previous active value
    logic [GPIO_WIDTH-1:0] edg_set;  // rising active value
    logic [GPIO_WIDTH-1:0] edg_q;    // sticky edge status

    //////////////////////////////
    // active value
    //////////////////////////////

    // input matches polarity, and only for enabled bits
    assign act = ~(in_data ^ irq_pol) & irq_en;

    //////////////////////////////
    // edge detection
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            act_dly <= '0;
        end else begin
            act_dly <= act;  // one edge behind
        end
    end

    assign edg_set = act & ~act_dly;

    // set wins over clear in the same cycle
    // bits out of edge mode or disabled drop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            edg_q <= '0;
        end else begin
            edg_q <= ((edg_q & ~irq_clr) | edg_set) & irq_en & irq_mode;
        end
    end

    //////////////////////////////
    // status and merge
    //////////////////////////////

    // level bits follow the active value, edge bits hold until cleared
    assign irq_sts = (act & ~irq_mode) | (edg_q & irq_mode);

    assign irq = |irq_sts;  // single line to the cpu

endmodule

// ==== logic/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs import gpio_pkg::*; #(
    parameter int unsigned GPIO_WIDTH  = 8,
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    // register access from the bus adapter
    input  logic                  wr_en,     // one-cycle strobe
    input  reg_idx_t              reg_idx,
    input  wb_data_t              wr_data,
    output wb_data_t              rd_data,   // combinational
    // pins
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out,
    output logic [GPIO_WIDTH-1:0] gpio_oe,
    output logic                  irq
);

    //////////////////////////////
    // local signals
    //////////////////////////////

    logic [GPIO_WIDTH-1:0] wr_bits;     // write data cut to pin width

    // configuration registers
    logic [GPIO_WIDTH-1:0] out_en_q;
    logic [GPIO_WIDTH-1:0] out_data_q;
    logic [GPIO_WIDTH-1:0] in_en_q;
    logic [GPIO_WIDTH-1:0] irq_en_q;
    logic [GPIO_WIDTH-1:0] irq_mode_q;
    logic [GPIO_WIDTH-1:0] irq_pol_q;

    // status side
    logic [GPIO_WIDTH-1:0] in_data;     // from synchronizer
    logic [GPIO_WIDTH-1:0] irq_clr;     // status clear mask
    logic [GPIO_WIDTH-1:0] irq_sts;

    assign wr_bits = wr_data[GPIO_WIDTH-1:0];  // upper bits dropped

    //////////////////////////////
    // register writes
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_en_q   <= '0;
            out_data_q <= '0;
            in_en_q    <= '0;
            irq_en_q   <= '0;
            irq_mode_q <= '0;
            irq_pol_q  <= '0;
        end else if (wr_en) begin
            case (reg_idx)
                REG_OUT_EN:   out_en_q   <= wr_bits;
                REG_OUT_DATA: out_data_q <= wr_bits;
                REG_IN_EN:    in_en_q    <= wr_bits;
                REG_IRQ_EN:   irq_en_q   <= wr_bits;
                REG_IRQ_MODE: irq_mode_q <= wr_bits;
                REG_IRQ_POL:  irq_pol_q  <= wr_bits;
                default: ;  // input data is read only, status handled below
            endcase
        end
    end

    // a write to status is a clear pulse, not a store
    assign irq_clr = (wr_en && reg_idx == REG_IRQ_STS) ? wr_bits : '0;

    assign gpio_out = out_data_q;
    assign gpio_oe  = out_en_q;   // zero after reset, pins float

    //////////////////////////////
    // input synchronizer
    //////////////////////////////

    gpio_sync #(
        .GPIO_WIDTH  (GPIO_WIDTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync (
        .clk     (clk),
        .rst     (rst),
        .gpio_in (gpio_in),
        .in_en   (in_en_q),
        .in_data (in_data)
    );

    //////////////////////////////
    // interrupt logic
    //////////////////////////////

    gpio_irq #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) u_irq (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .irq_en   (irq_en_q),
        .irq_mode (irq_mode_q),
        .irq_pol  (irq_pol_q),
        .irq_clr  (irq_clr),
        .irq_sts  (irq_sts),
        .irq      (irq)
    );

    //////////////////////////////
    // read multiplexer
    //////////////////////////////

    // every register zero-extended to a bus word
    always_comb begin
        case (reg_idx)
            REG_OUT_EN:   rd_data = wb_data_t'(out_en_q);
            REG_OUT_DATA: rd_data = wb_data_t'(out_data_q);
            REG_IN_EN:    rd_data = wb_data_t'(in_en_q);
            REG_IN_DATA:  rd_data = wb_data_t'(in_data);
            REG_IRQ_EN:   rd_data = wb_data_t'(irq_en_q);
            REG_IRQ_MODE: rd_data = wb_data_t'(irq_mode_q);
            REG_IRQ_POL:  rd_data = wb_data_t'(irq_pol_q);
            REG_IRQ_STS:  rd_data = wb_data_t'(irq_sts);
            default:      rd_data = '0;
        endcase
    end

endmodule

// ==== logic/wb_gpio_slave.sv ====
`timescale 1ns/1ps

module wb_gpio_slave import gpio_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // wishbone classic slave
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_adr_t  wb_adr,     // byte address
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,   // valid while ack is high
    output logic     wb_ack,
    // register block side
    output logic     wr_en,      // one-cycle write strobe
    output reg_idx_t reg_idx,
    output wb_data_t wr_data,
    input  wb_data_t rd_data     // combinational from register block
);

    logic req;     // new request this cycle
    logic ack_q;

    //////////////////////////////
    // request detect
    //////////////////////////////

    // a cycle already acked is not served again
    assign req = wb_cyc & wb_stb & ~ack_q;

    //////////////////////////////
    // acknowledge
    //////////////////////////////

    // fixed latency of one, no wait states
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;  // high for exactly one cycle
        end
    end

    assign wb_ack = ack_q;

    //////////////////////////////
    // write path
    //////////////////////////////

    // register updates on the same edge that raises ack
    assign wr_en   = req & wb_we;
    assign reg_idx = wb_adr[4:2];  // word index, byte offset ignored
    assign wr_data = wb_dat_w;     // full word, no byte selects

    //////////////////////////////
    // read path
    //////////////////////////////

    // captured at the ack edge, held until the next read
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// ==== logic/gpio_top.sv ====
`timescale 1ns/1ps

module gpio_top import gpio_pkg::*; #(
    parameter int unsigned GPIO_WIDTH  = 8,  // pins, 1 to 32
    parameter int unsigned SYNC_STAGES = 2   // at least 2
) (
    input  logic                  clk,
    input  logic                  rst,
    // wishbone classic slave
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  wb_adr_t               wb_adr,
    input  wb_data_t              wb_dat_w,
    output wb_data_t              wb_dat_r,
    output logic                  wb_ack,
    // pins
    input  logic [GPIO_WIDTH-1:0] gpio_in,   // asynchronous
    output logic [GPIO_WIDTH-1:0] gpio_out,
    output logic [GPIO_WIDTH-1:0] gpio_oe,
    output logic                  irq
);

    // adapter to register block
    logic     wr_en;
    reg_idx_t reg_idx;
    wb_data_t wr_data;
    wb_data_t rd_data;

    wb_gpio_slave u_wb_slave (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wr_en    (wr_en),
        .reg_idx  (reg_idx),
        .wr_data  (wr_data),
        .rd_data  (rd_data)
    );

    gpio_regs #(
        .GPIO_WIDTH  (GPIO_WIDTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_regs (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .reg_idx  (reg_idx),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .irq      (irq)
    );

endmodule

// ==== testbench/gpio_tb.sv ====
`timescale 1ns/1ps

module gpio_tb import gpio_pkg::*;;

    localparam int GPIO_W      = 8;
    localparam int SYNC_N      = 2;
    localparam int MAX_TESTS   = 100;
    localparam int ACK_LIMIT   = 4;      // cycles before a bus access gives up
    localparam wb_data_t SETTLE = 32'd4;  // wait after a pin change
    localparam wb_data_t PIN_MASK = {{(32-GPIO_W){1'b0}}, {GPIO_W{1'b1}}};

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,    // read and compare
        OP_PINS,    // drive gpio_in
        OP_WAIT,    // idle cycles
        OP_CHECK    // gpio_oe, gpio_out and irq
    } op_t;

    //////////////////////////////
    // dut signals
    //////////////////////////////

    logic              clk      = 1'b0;
    logic              rst      = 1'b1;
    logic              wb_cyc   = 1'b0;
    logic              wb_stb   = 1'b0;
    logic              wb_we    = 1'b0;
    wb_adr_t           wb_adr   = '0;
    wb_data_t          wb_dat_w = '0;
    wb_data_t          wb_dat_r;
    logic              wb_ack;
    logic [GPIO_W-1:0] gpio_in  = '0;
    logic [GPIO_W-1:0] gpio_out;
    logic [GPIO_W-1:0] gpio_oe;
    logic              irq;

    // stimulus table
    op_t      tbl_op   [MAX_TESTS];
    reg_idx_t tbl_idx  [MAX_TESTS];
    wb_data_t tbl_data [MAX_TESTS];  // write data, pin value, wait count or irq
    wb_data_t tbl_exp  [MAX_TESTS];
    string    tbl_name [MAX_TESTS];
    int       n_tests = 0;

    logic [GPIO_W-1:0] cur_oe  = '0;  // pin state the table expects
    logic [GPIO_W-1:0] cur_out = '0;
    logic [31:0]       lcg_state = 32'd64;

    int   pass_cnt    = 0;
    int   fail_cnt    = 0;
    int   other_errs  = 0;  // protocol and table errors outside a test
    int   cycle_cnt   = 0;
    int   cycle_limit = 0;
    bit   test_err;
    bit   bus_busy    = 1'b0;
    logic ack_prev    = 1'b0;

    gpio_top #(
        .GPIO_WIDTH  (GPIO_W),
        .SYNC_STAGES (SYNC_N)
    ) u_gpio_top (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .irq      (irq)
    );

    always #10 clk = ~clk;  // 20 ns period

    //////////////////////////////
    // watchdogs
    //////////////////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ack must never be high two cycles running
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_ack && ack_prev) begin
                $display("ack stayed high for more than one cycle");
                other_errs++;
            end
            ack_prev = wb_ack;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic wb_data_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes lcg
        return lcg_state;
    endfunction

    function automatic wb_data_t pins_word();
        return wb_data_t'({cur_oe, cur_out});  // oe in the upper byte
    endfunction

    task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            test_err = 1'b1;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            test_err = 1'b1;
        end
    endtask

    task automatic add_test(input op_t op, input reg_idx_t idx, input wb_data_t data,
                            input wb_data_t exp, input string name);
        if (n_tests >= MAX_TESTS) begin
            $display("stimulus table is full, %s was dropped", name);
            other_errs++;
        end else begin
            tbl_op[n_tests]   = op;
            tbl_idx[n_tests]  = idx;
            tbl_data[n_tests] = data;
            tbl_exp[n_tests]  = exp;
            tbl_name[n_tests] = name;
            n_tests++;
        end
    endtask

    // one classic cycle, request on a rising edge, ack sampled mid cycle
    task automatic bus_access(input logic we, input reg_idx_t idx, input wb_data_t wdata,
                              input string name, output wb_data_t rdata);
        int   cycles;
        logic got_ack;
        cycles  = 0;
        got_ack = 1'b0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= {idx, 2'b00};  // byte address of the word
        wb_dat_w <= wdata;
        bus_busy = 1'b1;
        while (!got_ack && cycles < ACK_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            got_ack = wb_ack;
        end
        rdata = wb_dat_r;  // valid while ack is high
        if (!got_ack) begin
            $display("no ack for %s within %0d cycles", name, ACK_LIMIT);
            test_err = 1'b1;
        end else if (cycles != 1) begin
            $display("ack for %s came %0d cycles after the request instead of 1",
                     name, cycles);
            test_err = 1'b1;
        end
    endtask

    // drop stb on the edge after ack
    task automatic release_bus();
        if (bus_busy) begin
            @(posedge clk);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            bus_busy = 1'b0;
        end
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    task automatic build_table();
        reg_idx_t cfg_regs  [6];
        string    cfg_names [6];
        wb_data_t value;
        cfg_regs  = '{REG_OUT_EN, REG_OUT_DATA, REG_IN_EN,
                      REG_IRQ_EN, REG_IRQ_MODE, REG_IRQ_POL};
        cfg_names = '{"out_en", "out_data", "in_en", "irq_en", "irq_mode", "irq_pol"};

        // reset values
        for (int k = 0; k < 8; k++) begin
            add_test(OP_READ, reg_idx_t'(k), '0, '0, $sformatf("reset_reg_%0d", k));
        end
        add_test(OP_CHECK, REG_OUT_EN, 32'd0, pins_word(), "reset_pins_irq");

        // random config read back, pins follow right after ack
        for (int k = 0; k < 6; k++) begin
            value = next_random();
            add_test(OP_WRITE, cfg_regs[k], value, '0, {"wr_", cfg_names[k]});
            if (cfg_regs[k] == REG_OUT_EN) begin
                cur_oe = value[GPIO_W-1:0];
                add_test(OP_CHECK, REG_OUT_EN, 32'd0, pins_word(), "pins_after_out_en");
            end else if (cfg_regs[k] == REG_OUT_DATA) begin
                cur_out = value[GPIO_W-1:0];
                add_test(OP_CHECK, REG_OUT_EN, 32'd0, pins_word(), "pins_after_out_data");
            end
            add_test(OP_READ, cfg_regs[k], '0, value & PIN_MASK, {"rd_", cfg_names[k]});
        end

        // input path, masked by in_en
        add_test(OP_WRITE, REG_IRQ_EN, 32'd0, '0, "clr_irq_en");
        add_test(OP_WRITE, REG_IRQ_MODE, 32'd0, '0, "clr_irq_mode");
        add_test(OP_WRITE, REG_IRQ_POL, 32'd0, '0, "clr_irq_pol");
        add_test(OP_WRITE, REG_IN_EN, 32'h0000_003C, '0, "in_en_mask");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_00A5, '0, "pins_a5");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "settle_a5");
        add_test(OP_READ, REG_IN_DATA, '0, 32'h0000_00A5 & 32'h0000_003C, "in_data_a5");
        add_test(OP_WRITE, REG_IN_DATA, 32'h0000_00FF, '0, "wr_in_data");  // read only
        add_test(OP_READ, REG_IN_DATA, '0, 32'h0000_00A5 & 32'h0000_003C, "in_data_kept");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_005A, '0, "pins_5a");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "settle_5a");
        add_test(OP_READ, REG_IN_DATA, '0, 32'h0000_005A & 32'h0000_003C, "in_data_5a");

        // level interrupt on bit 0, active high
        add_test(OP_WRITE, REG_IN_EN, 32'h0000_00FF, '0, "in_en_all");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_0000, '0, "pins_low");
        add_test(OP_WRITE, REG_IRQ_EN, 32'h0000_0001, '0, "lvl_irq_en");
        add_test(OP_WRITE, REG_IRQ_MODE, 32'h0000_0000, '0, "lvl_irq_mode");
        add_test(OP_WRITE, REG_IRQ_POL, 32'h0000_0001, '0, "lvl_pol_high");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_0001, '0, "lvl_pin_high");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "lvl_settle_high");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0001, "lvl_sts_set");
        add_test(OP_CHECK, REG_OUT_EN, 32'd1, pins_word(), "lvl_irq_set");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_0000, '0, "lvl_pin_low");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "lvl_settle_low");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0000, "lvl_sts_gone");
        add_test(OP_CHECK, REG_OUT_EN, 32'd0, pins_word(), "lvl_irq_gone");

        // active low, pin already low
        add_test(OP_WRITE, REG_IRQ_POL, 32'h0000_0000, '0, "lvl_pol_low");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "inv_settle");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0001, "inv_sts_set");
        add_test(OP_CHECK, REG_OUT_EN, 32'd1, pins_word(), "inv_irq_set");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_0001, '0, "inv_pin_high");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "inv_settle_high");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0000, "inv_sts_gone");
        add_test(OP_CHECK, REG_OUT_EN, 32'd0, pins_word(), "inv_irq_gone");

        // only bit 0 enabled, the other active pins stay out of status
        add_test(OP_WRITE, REG_IRQ_POL, 32'h0000_00FF, '0, "dis_pol_high");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_00FF, '0, "dis_pins_high");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "dis_settle");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0001, "dis_sts_bit0");
        add_test(OP_CHECK, REG_OUT_EN, 32'd1, pins_word(), "dis_irq_set");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_0000, '0, "dis_pins_low");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "dis_settle_low");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0000, "dis_sts_gone");

        // sticky rising edge on bit 1
        add_test(OP_WRITE, REG_IRQ_EN, 32'h0000_0002, '0, "edg_irq_en");
        add_test(OP_WRITE, REG_IRQ_MODE, 32'h0000_0002, '0, "edg_irq_mode");
        add_test(OP_WRITE, REG_IRQ_POL, 32'h0000_0002, '0, "edg_pol_rise");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_0002, '0, "edg_pin_high");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "edg_settle_high");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0002, "edg_sts_set");
        add_test(OP_CHECK, REG_OUT_EN, 32'd1, pins_word(), "edg_irq_set");
        add_test(OP_PINS, REG_OUT_EN, 32'h0000_0000, '0, "edg_pin_low");
        add_test(OP_WAIT, REG_OUT_EN, SETTLE, '0, "edg_settle_low");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0002, "edg_sts_sticky");
        add_test(OP_CHECK, REG_OUT_EN, 32'd1, pins_word(), "edg_irq_sticky");
        add_test(OP_WRITE, REG_IRQ_STS, 32'h0000_0000, '0, "edg_wr_zero");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0002, "edg_sts_kept");
        add_test(OP_WRITE, REG_IRQ_STS, 32'h0000_0002, '0, "edg_wr_one");
        add_test(OP_READ, REG_IRQ_STS, '0, 32'h0000_0000, "edg_sts_cleared");
        add_test(OP_CHECK, REG_OUT_EN, 32'd0, pins_word(), "edg_irq_cleared");
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        wb_data_t rdata;
        build_table();
        cycle_limit = n_tests * 10 + 20;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < n_tests; i++) begin
            test_err = 1'b0;
            case (tbl_op[i])
                OP_WRITE: bus_access(1'b1, tbl_idx[i], tbl_data[i], tbl_name[i], rdata);
                OP_READ: begin
                    bus_access(1'b0, tbl_idx[i], '0, tbl_name[i], rdata);
                    check_data(tbl_name[i], tbl_exp[i], rdata);
                end
                OP_PINS: begin
                    release_bus();
                    @(posedge clk);
                    gpio_in <= tbl_data[i][GPIO_W-1:0];
                end
                OP_WAIT: begin
                    release_bus();
                    repeat (tbl_data[i]) @(posedge clk);
                end
                OP_CHECK: begin
                    // still in the ack cycle after a bus access, else wait to mid cycle
                    if (!bus_busy) begin
                        @(negedge clk);
                    end
                    check_data(tbl_name[i], tbl_exp[i], wb_data_t'({gpio_oe, gpio_out}));
                    check_bit(tbl_name[i], tbl_data[i][0], irq);
                    release_bus();
                end
                default: begin
                    $display("unknown operation in table entry %s", tbl_name[i]);
                    test_err = 1'b1;
                end
            endcase
            if (test_err) begin
                fail_cnt++;
                $display("bad  %s", tbl_name[i]);
            end else begin
                pass_cnt++;
                $display("ok   %s", tbl_name[i]);
            end
        end
        release_bus();

        $display("tests: %0d ok, %0d bad, %0d other errors", pass_cnt, fail_cnt, other_errs);
        if (fail_cnt == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/gpio_pkg.sv
logic/gpio_sync.sv
logic/gpio_irq.sv
logic/gpio_regs.sv
logic/wb_gpio_slave.sv
logic/gpio_top.sv
testbench/gpio_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module gpio_tb -f src.f -o sim_gpio

sim_out=$(./obj_dir/sim_gpio)
echo "$sim_out"

if echo "$sim_out" | grep -q "Result: PASSED"; then
    exit 0
else
    exit 1
fi
